// ==== filelist.f ====
+incdir+verification
design/ofdm_pkg.sv
design/reorder_pkg.sv
design/prefix_remover.sv
design/reorder_ctrl.sv
design/bitrev_buffer.sv
design/rx_front_end.sv
verification/tb_rx_front_end.sv

// ==== Makefile ====
# Verilator simulation of the OFDM receiver front end

TOP = tb_rx_front_end

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): filelist.f design/*.sv verification/*.sv verification/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	@./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TESTS FAILED" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int check_count = 0;
int error_count = 0;

// Sample values, printed signed
task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
endtask

// Strobe levels
task automatic check_level(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

// Edge numbers counted from time zero
task automatic check_cycle(input string name, input int got, input int exp);
    check_count++;
    if (got != exp) begin
        error_count++;
        $display("CHECK FAILED at %0t: %s got edge %0d expected edge %0d",
                 $time, name, got, exp);
    end
endtask

`endif

// ==== verification/tb_rx_front_end.sv ====
`timescale 1ns/1ps

module tb_rx_front_end;
    import ofdm_pkg::*;

    localparam int WAIT_LIMIT = 1000;
    localparam int IDLE_CYCLES = 20;
    localparam int MODEL_DEPTH = 512;

    logic    clk;
    logic    rst;
    logic    in_valid;
    sample_t sig0_re;
    sample_t sig0_im;
    sample_t sig1_re;
    sample_t sig1_im;
    sample_t sig2_re;
    sample_t sig2_im;
    logic    out_valid;
    sample_t out0_re;
    sample_t out0_im;
    sample_t out1_re;
    sample_t out1_im;
    sample_t out2_re;
    sample_t out2_im;

    int seed = 32'hf4e0;
    int cyc = 0;
    int total;
    int burst_sym;
    int test_errors;
    int rise_q[$];

    // Every driven sample per antenna since the last reset
    sample_t model_re [3][MODEL_DEPTH];
    sample_t model_im [3][MODEL_DEPTH];

    `include "tb_checks.svh"

    rx_front_end u_rx_front_end (
        .clk(clk), .rst(rst), .in_valid(in_valid),
        .sig0_re(sig0_re), .sig0_im(sig0_im),
        .sig1_re(sig1_re), .sig1_im(sig1_im),
        .sig2_re(sig2_re), .sig2_im(sig2_im),
        .out_valid(out_valid),
        .out0_re(out0_re), .out0_im(out0_im),
        .out1_re(out1_re), .out1_im(out1_im),
        .out2_re(out2_re), .out2_im(out2_im)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic int reverse_bits(input int value);
        int result;
        result = 0;
        for (int i = 0; i < BIN_ADDR_WIDTH; i++) begin
            result = (result << 1) | ((value >> i) & 1);
        end
        return result;
    endfunction

    function automatic sample_t out_re(input int ant);
        case (ant)
            0: return out0_re;
            1: return out1_re;
            default: return out2_re;
        endcase
    endfunction

    function automatic sample_t out_im(input int ant);
        case (ant)
            0: return out0_im;
            1: return out1_im;
            default: return out2_im;
        endcase
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        in_valid <= 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        total = 0;
        burst_sym = 0;
        rise_q.delete();
    endtask

    task automatic drive_samples(input int count, input int density);
        int sent;
        logic v;
        sample_t s [6];
        sent = 0;
        while (sent < count) begin
            @(posedge clk);
            v = ($unsigned($random(seed)) % 100) < density;
            for (int i = 0; i < 6; i++) begin
                s[i] = sample_t'($random(seed));
            end
            in_valid <= v;
            sig0_re <= s[0];
            sig0_im <= s[1];
            sig1_re <= s[2];
            sig1_im <= s[3];
            sig2_re <= s[4];
            sig2_im <= s[5];
            if (v) begin
                for (int a = 0; a < 3; a++) begin
                    model_re[a][total] = s[2*a];
                    model_im[a][total] = s[2*a+1];
                end
                // cyc + 2 is the edge that samples this in_valid
                if (total % SYMBOL_LEN == SYMBOL_LEN - 1) begin
                    rise_q.push_back(cyc + 2 + 3);
                end
                total++;
                sent++;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic collect_bursts(input int count);
        int waited;
        int idx;
        @(negedge clk);
        for (int b = 0; b < count; b++) begin
            waited = 0;
            while (out_valid !== 1'b1 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (out_valid !== 1'b1) begin
                $display("Timed out waiting for output burst %0d", b);
                error_count++;
                return;
            end
            if (rise_q.size() == 0) begin
                $display("Output burst %0d started with no complete input symbol", b);
                error_count++;
            end else begin
                check_cycle("out_valid rise", cyc, rise_q.pop_front());
            end
            for (int k = 0; k < FFT_LEN; k++) begin
                if (k > 0) begin
                    @(negedge clk);
                end
                check_level("out_valid", out_valid, 1'b1);
                idx = burst_sym * SYMBOL_LEN + PREFIX_LEN + reverse_bits(k);
                for (int a = 0; a < 3; a++) begin
                    check_sample($sformatf("out%0d_re", a), out_re(a), model_re[a][idx]);
                    check_sample($sformatf("out%0d_im", a), out_im(a), model_im[a][idx]);
                end
            end
            // Burst ends after exactly one symbol of bins
            @(negedge clk);
            check_level("out_valid after burst", out_valid, 1'b0);
            burst_sym++;
        end
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_level("out_valid", out_valid, 1'b0);
            for (int a = 0; a < 3; a++) begin
                check_sample($sformatf("out%0d_re", a), out_re(a), sample_t'(0));
                check_sample($sformatf("out%0d_im", a), out_im(a), sample_t'(0));
            end
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s: %0d errors", name, error_count - test_errors);
    endtask

    initial begin
        rst = 1'b1;
        in_valid = 1'b0;
        sig0_re = '0;
        sig0_im = '0;
        sig1_re = '0;
        sig1_im = '0;
        sig2_re = '0;
        sig2_im = '0;
        apply_reset();

        test_errors = error_count;
        watch_idle(IDLE_CYCLES);
        report_test("idle after reset");

        // Three symbols and a partial one at about 70% density
        test_errors = error_count;
        fork
            drive_samples(3 * SYMBOL_LEN + 40, 70);
            collect_bursts(3);
        join
        watch_idle(2 * SYMBOL_LEN);
        report_test("random valid with partial symbol");

        apply_reset();
        test_errors = error_count;
        fork
            drive_samples(4 * SYMBOL_LEN, 100);
            collect_bursts(4);
        join
        watch_idle(SYMBOL_LEN);
        report_test("back-to-back symbols");

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/rx_front_end.sv ====
`timescale 1ns/1ps

module rx_front_end (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ofdm_pkg::sample_t sig0_re,
    input  ofdm_pkg::sample_t sig0_im,
    input  ofdm_pkg::sample_t sig1_re,
    input  ofdm_pkg::sample_t sig1_im,
    input  ofdm_pkg::sample_t sig2_re,
    input  ofdm_pkg::sample_t sig2_im,
    output logic              out_valid,
    output ofdm_pkg::sample_t out0_re,
    output ofdm_pkg::sample_t out0_im,
    output ofdm_pkg::sample_t out1_re,
    output ofdm_pkg::sample_t out1_im,
    output ofdm_pkg::sample_t out2_re,
    output ofdm_pkg::sample_t out2_im
);
    import ofdm_pkg::*;
    import reorder_pkg::*;

    logic      keep_valid;
    sample_t   keep0_re;
    sample_t   keep0_im;
    sample_t   keep1_re;
    sample_t   keep1_im;
    sample_t   keep2_re;
    sample_t   keep2_im;

    logic      wr_en;
    bank_t     wr_bank;
    bin_addr_t wr_addr;
    logic      rd_en;
    bank_t     rd_bank;
    bin_addr_t rd_addr;

    prefix_remover u_prefix_remover (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .sig0_re   (sig0_re),
        .sig0_im   (sig0_im),
        .sig1_re   (sig1_re),
        .sig1_im   (sig1_im),
        .sig2_re   (sig2_re),
        .sig2_im   (sig2_im),
        .keep_valid(keep_valid),
        .keep0_re  (keep0_re),
        .keep0_im  (keep0_im),
        .keep1_re  (keep1_re),
        .keep1_im  (keep1_im),
        .keep2_re  (keep2_re),
        .keep2_im  (keep2_im)
    );

    // One controller drives all three antenna buffers
    reorder_ctrl u_reorder_ctrl (
        .clk       (clk),
        .rst       (rst),
        .keep_valid(keep_valid),
        .wr_en     (wr_en),
        .wr_bank   (wr_bank),
        .wr_addr   (wr_addr),
        .rd_en     (rd_en),
        .rd_bank   (rd_bank),
        .rd_addr   (rd_addr),
        .out_valid (out_valid)
    );

    bitrev_buffer u_buf0 (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
        .wr_re(keep0_re), .wr_im(keep0_im),
        .rd_en(rd_en), .rd_bank(rd_bank), .rd_addr(rd_addr),
        .rd_re(out0_re), .rd_im(out0_im)
    );

    bitrev_buffer u_buf1 (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
        .wr_re(keep1_re), .wr_im(keep1_im),
        .rd_en(rd_en), .rd_bank(rd_bank), .rd_addr(rd_addr),
        .rd_re(out1_re), .rd_im(out1_im)
    );

    bitrev_buffer u_buf2 (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
        .wr_re(keep2_re), .wr_im(keep2_im),
        .rd_en(rd_en), .rd_bank(rd_bank), .rd_addr(rd_addr),
        .rd_re(out2_re), .rd_im(out2_im)
    );

endmodule

// ==== design/bitrev_buffer.sv ====
`timescale 1ns/1ps

module bitrev_buffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  reorder_pkg::bank_t  wr_bank,
    input  ofdm_pkg::bin_addr_t wr_addr,
    input  ofdm_pkg::sample_t   wr_re,
    input  ofdm_pkg::sample_t   wr_im,
    input  logic                rd_en,
    input  reorder_pkg::bank_t  rd_bank,
    input  ofdm_pkg::bin_addr_t rd_addr,
    output ofdm_pkg::sample_t   rd_re,
    output ofdm_pkg::sample_t   rd_im
);
    import ofdm_pkg::*;

    // Bank select is the top address bit
    logic [BIN_ADDR_WIDTH:0] wr_index;
    logic [BIN_ADDR_WIDTH:0] rd_index;

    sample_t mem_re [2*FFT_LEN];
    sample_t mem_im [2*FFT_LEN];

    assign wr_index = {wr_bank, wr_addr};
    assign rd_index = {rd_bank, rd_addr};

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_re[wr_index] <= wr_re;
            mem_im[wr_index] <= wr_im;
        end
    end

    // Output reads zero outside a burst
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_re <= '0;
            rd_im <= '0;
        end else if (rd_en) begin
            rd_re <= mem_re[rd_index];
            rd_im <= mem_im[rd_index];
        end else begin
            rd_re <= '0;
            rd_im <= '0;
        end
    end

endmodule

// ==== design/reorder_ctrl.sv ====
`timescale 1ns/1ps

module reorder_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 keep_valid,
    output logic                 wr_en,
    output reorder_pkg::bank_t   wr_bank,
    output ofdm_pkg::bin_addr_t  wr_addr,
    output logic                 rd_en,
    output reorder_pkg::bank_t   rd_bank,
    output ofdm_pkg::bin_addr_t  rd_addr,
    output logic                 out_valid
);
    import ofdm_pkg::*;
    import reorder_pkg::*;

    bin_addr_t   wr_count;
    logic        wr_last;
    logic        full;
    bank_t       full_bank;
    read_state_t read_state;
    read_state_t full_state;
    logic        rd_last;

    assign wr_en = keep_valid;
    assign wr_last = keep_valid && (wr_count == bin_addr_t'(FFT_LEN - 1));

    // Bit-reversed write address
    always_comb begin
        for (int i = 0; i < BIN_ADDR_WIDTH; i++) begin
            wr_addr[i] = wr_count[BIN_ADDR_WIDTH-1-i];
        end
    end

    // Write side counts kept samples and swaps banks every 64
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_count <= '0;
            wr_bank <= BANK_A;
            full <= 1'b0;
            full_bank <= BANK_A;
        end else begin
            full <= wr_last;
            if (keep_valid) begin
                wr_count <= wr_count + bin_addr_t'(1);
            end
            if (wr_last) begin
                full_bank <= wr_bank;
                wr_bank <= (wr_bank == BANK_A) ? BANK_B : BANK_A;
            end
        end
    end

    // The most recently filled bank is the one to read next
    assign full_state = (full_bank == BANK_A) ? READ_A : READ_B;
    assign rd_last = (rd_addr == bin_addr_t'(FFT_LEN - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_state <= READ_IDLE;
            rd_addr <= '0;
        end else begin
            case (read_state)
                READ_IDLE: begin
                    rd_addr <= '0;
                    if (full) begin
                        read_state <= full_state;
                    end
                end
                default: begin
                    rd_addr <= rd_addr + bin_addr_t'(1);
                    if (rd_last) begin
                        // Go straight on if the other bank has just filled
                        if (full) begin
                            read_state <= full_state;
                        end else begin
                            read_state <= READ_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    assign rd_en = (read_state != READ_IDLE);
    assign rd_bank = (read_state == READ_B) ? BANK_B : BANK_A;

    // Aligned with the registered buffer read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rd_en;
        end
    end

    a_no_bank_clash: assert property (
        @(posedge clk) disable iff (rst)
        (rd_en && wr_en) |-> (rd_bank != wr_bank)
    );

    a_burst_len: assert property (
        @(posedge clk) disable iff (rst)
        $rose(out_valid) |-> ##(FFT_LEN) !out_valid
    );

endmodule

// ==== design/prefix_remover.sv ====
`timescale 1ns/1ps

module prefix_remover (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  ofdm_pkg::sample_t sig0_re,
    input  ofdm_pkg::sample_t sig0_im,
    input  ofdm_pkg::sample_t sig1_re,
    input  ofdm_pkg::sample_t sig1_im,
    input  ofdm_pkg::sample_t sig2_re,
    input  ofdm_pkg::sample_t sig2_im,
    output logic             keep_valid,
    output ofdm_pkg::sample_t keep0_re,
    output ofdm_pkg::sample_t keep0_im,
    output ofdm_pkg::sample_t keep1_re,
    output ofdm_pkg::sample_t keep1_im,
    output ofdm_pkg::sample_t keep2_re,
    output ofdm_pkg::sample_t keep2_im
);
    import ofdm_pkg::*;

    sym_pos_t sym_pos;
    logic     pos_last;
    logic     in_prefix;

    assign pos_last = (sym_pos == sym_pos_t'(SYMBOL_LEN - 1));
    assign in_prefix = (sym_pos < sym_pos_t'(PREFIX_LEN));

    // Symbol position counts from the first valid sample after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sym_pos <= '0;
            keep_valid <= 1'b0;
        end else begin
            keep_valid <= in_valid && !in_prefix;
            if (in_valid) begin
                if (pos_last) begin
                    sym_pos <= '0;
                end else begin
                    sym_pos <= sym_pos + sym_pos_t'(1);
                end
            end
        end
    end

    // Sample registers qualified by keep_valid downstream
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            keep0_re <= '0;
            keep0_im <= '0;
            keep1_re <= '0;
            keep1_im <= '0;
            keep2_re <= '0;
            keep2_im <= '0;
        end else if (in_valid) begin
            keep0_re <= sig0_re;
            keep0_im <= sig0_im;
            keep1_re <= sig1_re;
            keep1_im <= sig1_im;
            keep2_re <= sig2_re;
            keep2_im <= sig2_im;
        end
    end

    a_pos_range: assert property (
        @(posedge clk) disable iff (rst)
        sym_pos <= sym_pos_t'(SYMBOL_LEN - 1)
    );

endmodule

// ==== design/reorder_pkg.sv ====
package reorder_pkg;

    // Half of the ping-pong buffer
    typedef enum logic {
        BANK_A,
        BANK_B
    } bank_t;

    // Read sequencer state
    typedef enum logic [1:0] {
        READ_IDLE,
        READ_A,
        READ_B
    } read_state_t;

endpackage

// ==== design/ofdm_pkg.sv ====
package ofdm_pkg;

    // Fixed point format of one real or imaginary part
    localparam int SAMPLE_WIDTH = 16;

    // OFDM symbol framing
    localparam int SYMBOL_LEN = 80;
    localparam int PREFIX_LEN = 16;
    localparam int FFT_LEN = SYMBOL_LEN - PREFIX_LEN;

    localparam int BIN_ADDR_WIDTH = $clog2(FFT_LEN);
    localparam int SYM_POS_WIDTH = $clog2(SYMBOL_LEN);

    // Receive antennas, each with its own loose sample ports
    localparam int NUM_ANT = 3;

    // One real or imaginary part
    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // Address within one buffer bank, also the bin index
    typedef logic [BIN_ADDR_WIDTH-1:0] bin_addr_t;

    // Sample position inside a symbol, prefix included
    typedef logic [SYM_POS_WIDTH-1:0] sym_pos_t;

endpackage
